//--- hw/cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Data widths
`define CACHE_WORD_W      16
`define CACHE_ADDR_W      16

// Line geometry, four words per line
`define CACHE_LINE_WORDS  4
`define CACHE_LINE_W      64

// Word address split into tag, index and offset
// Offset is bits 1..0, index is bit 2, tag is bits 15..3
`define CACHE_OFF_W       2
`define CACHE_IDX_W       1
`define CACHE_TAG_W       13

// External memory response delay in cycles
`define MEM_LATENCY       3

`endif

//--- hw/mem_bus_pkg.sv
`default_nettype none
`include "cache_consts.svh"

package mem_bus_pkg;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    // Word accesses only come from write misses
    typedef enum logic {
        MEM_SIZE_WORD = 1'b0,
        MEM_SIZE_LINE = 1'b1
    } mem_size_e;

    // Held by the requester until the ready pulse
    typedef struct packed {
        logic                      valid;
        mem_op_e                   op;
        mem_size_e                 size;
        logic [`CACHE_ADDR_W-1:0]  addr;
        logic [`CACHE_LINE_W-1:0]  wdata;
    } mem_req_t;

    typedef struct packed {
        logic                      ready;
        logic [`CACHE_LINE_W-1:0]  rdata;
    } mem_rsp_t;

    // Write address seen by the other cache
    typedef struct packed {
        logic                      valid;
        logic [`CACHE_ADDR_W-1:0]  addr;
    } snoop_t;

endpackage

`default_nettype wire

//--- hw/cache_pkg.sv
`default_nettype none
`include "cache_consts.svh"

package cache_pkg;

    typedef enum logic {
        CPU_READ  = 1'b0,
        CPU_WRITE = 1'b1
    } cpu_op_e;

    typedef struct packed {
        logic                      valid;
        cpu_op_e                   op;
        logic [`CACHE_ADDR_W-1:0]  addr;
        logic [`CACHE_WORD_W-1:0]  wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                      valid;
        logic [`CACHE_WORD_W-1:0]  rdata;
    } cpu_rsp_t;

    // POST states mean a line write is still outstanding on the memory bus
    typedef enum logic [2:0] {
        ST_IDLE        = 3'd0,
        ST_LOOKUP      = 3'd1,
        ST_MEM_RD      = 3'd2,
        ST_MEM_WR      = 3'd3,
        ST_POST_WR     = 3'd4,
        ST_POST_LOOKUP = 3'd5
    } cache_state_e;

endpackage

`default_nettype wire

//--- hw/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_consts.svh"

module cache_ctrl
    import mem_bus_pkg::*;
    import cache_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset_n,
    input  wire cpu_req_t  i_cpu_req,
    output logic           o_cpu_ready,
    output cpu_rsp_t       o_cpu_rsp,
    output mem_req_t       o_mem_req,
    input  wire mem_rsp_t  i_mem_rsp,
    input  wire snoop_t    i_snoop
);

    localparam int WAYS = 2;
    localparam int SETS = 1 << `CACHE_IDX_W;

    cache_state_e state_q;
    cache_state_e state_d;
    cpu_req_t     req_q;

    // Tag, valid, LRU and data arrays
    logic [WAYS-1:0]           valid_q [SETS];
    logic                      lru_q   [SETS];
    logic [`CACHE_TAG_W-1:0]   tag_q   [SETS][WAYS];
    logic [`CACHE_LINE_W-1:0]  data_q  [SETS][WAYS];

    // Memory request and processor response registers
    logic                      mem_valid_q;
    mem_op_e                   mem_op_q;
    mem_size_e                 mem_size_q;
    logic [`CACHE_ADDR_W-1:0]  mem_addr_q;
    logic [`CACHE_LINE_W-1:0]  mem_wdata_q;
    logic                      rsp_valid_q;
    logic [`CACHE_WORD_W-1:0]  rsp_data_q;

    logic [`CACHE_OFF_W-1:0]   req_off;
    logic [`CACHE_IDX_W-1:0]   req_idx;
    logic [`CACHE_TAG_W-1:0]   req_tag;
    logic [`CACHE_ADDR_W-1:0]  line_addr;
    logic [`CACHE_IDX_W-1:0]   snp_idx;
    logic [`CACHE_TAG_W-1:0]   snp_tag;

    logic [WAYS-1:0]           hit_way;
    logic                      hit;
    logic                      hit_sel;
    logic                      victim;
    logic [`CACHE_LINE_W-1:0]  hit_line;
    logic [`CACHE_WORD_W-1:0]  hit_word;
    logic [`CACHE_LINE_W-1:0]  merged_line;

    logic accept;
    logic mem_done;
    logic serve_rd;
    logic start_rd;
    logic start_line_wr;
    logic start_word_wr;
    logic fill;

    assign req_off   = req_q.addr[`CACHE_OFF_W-1:0];
    assign req_idx   = req_q.addr[`CACHE_OFF_W +: `CACHE_IDX_W];
    assign req_tag   = req_q.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign line_addr = {req_q.addr[`CACHE_ADDR_W-1:`CACHE_OFF_W], {`CACHE_OFF_W{1'b0}}};
    assign snp_idx   = i_snoop.addr[`CACHE_OFF_W +: `CACHE_IDX_W];
    assign snp_tag   = i_snoop.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];

    assign o_cpu_ready = (state_q == ST_IDLE) || (state_q == ST_POST_WR);
    assign accept      = i_cpu_req.valid && o_cpu_ready;
    assign mem_done    = mem_valid_q && i_mem_rsp.ready;

    assign o_mem_req = '{valid: mem_valid_q, op: mem_op_q, size: mem_size_q,
                         addr: mem_addr_q, wdata: mem_wdata_q};
    assign o_cpu_rsp = '{valid: rsp_valid_q, rdata: rsp_data_q};

    // Tag compare for both ways of the addressed set
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit_way[w] = valid_q[req_idx][w] && (tag_q[req_idx][w] == req_tag);
        end
    end

    assign hit      = |hit_way;
    assign hit_sel  = hit_way[1];
    assign hit_line = data_q[req_idx][hit_sel];
    assign hit_word = hit_line[req_off*`CACHE_WORD_W +: `CACHE_WORD_W];

    // Invalid way first, otherwise the LRU way
    assign victim = !valid_q[req_idx][0] ? 1'b0 :
                    !valid_q[req_idx][1] ? 1'b1 : lru_q[req_idx];

    always_comb begin
        merged_line = hit_line;
        merged_line[req_off*`CACHE_WORD_W +: `CACHE_WORD_W] = req_q.wdata;
    end

    always_comb begin
        state_d       = state_q;
        serve_rd      = 1'b0;
        start_rd      = 1'b0;
        start_line_wr = 1'b0;
        start_word_wr = 1'b0;
        fill          = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_POST_WR: begin
                if (accept) begin
                    state_d = mem_done ? ST_LOOKUP : ST_POST_LOOKUP;
                end else if (mem_done) begin
                    state_d = ST_IDLE;
                end
            end
            ST_LOOKUP: begin
                if (req_q.op == CPU_READ) begin
                    if (hit) begin
                        serve_rd = 1'b1;
                        state_d  = ST_IDLE;
                    end else begin
                        start_rd = 1'b1;
                        state_d  = ST_MEM_RD;
                    end
                end else if (hit) begin
                    start_line_wr = 1'b1;
                    state_d       = ST_POST_WR;
                end else begin
                    start_word_wr = 1'b1;
                    state_d       = ST_MEM_WR;
                end
            end
            ST_POST_LOOKUP: begin
                // Only a read hit may pass the posted write
                if (req_q.op == CPU_READ && hit) begin
                    serve_rd = 1'b1;
                    state_d  = mem_done ? ST_IDLE : ST_POST_WR;
                end else if (mem_done) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_MEM_RD: begin
                if (mem_done) begin
                    fill    = 1'b1;
                    state_d = ST_IDLE;
                end
            end
            ST_MEM_WR: begin
                if (mem_done) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state_q     <= ST_IDLE;
            mem_valid_q <= 1'b0;
            rsp_valid_q <= 1'b0;
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                lru_q[s]   <= 1'b0;
            end
        end else begin
            state_q     <= state_d;
            rsp_valid_q <= serve_rd || fill;
            if (start_rd || start_line_wr || start_word_wr) begin
                mem_valid_q <= 1'b1;
            end else if (mem_done) begin
                mem_valid_q <= 1'b0;
            end
            // LRU points at the way not used last
            if (serve_rd || start_line_wr) begin
                lru_q[req_idx] <= ~hit_sel;
            end
            if (fill) begin
                valid_q[req_idx][victim] <= 1'b1;
                lru_q[req_idx]           <= ~victim;
            end
            // Snoop invalidate comes last so it wins over a fill
            if (i_snoop.valid) begin
                for (int w = 0; w < WAYS; w++) begin
                    if (tag_q[snp_idx][w] == snp_tag) begin
                        valid_q[snp_idx][w] <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= i_cpu_req;
        end
        if (serve_rd) begin
            rsp_data_q <= hit_word;
        end
        if (fill) begin
            rsp_data_q              <= i_mem_rsp.rdata[req_off*`CACHE_WORD_W +: `CACHE_WORD_W];
            tag_q[req_idx][victim]  <= req_tag;
            data_q[req_idx][victim] <= i_mem_rsp.rdata;
        end
        if (start_rd) begin
            mem_op_q   <= MEM_READ;
            mem_size_q <= MEM_SIZE_LINE;
            mem_addr_q <= line_addr;
        end
        // Write hit updates the line and sends all of it
        if (start_line_wr) begin
            data_q[req_idx][hit_sel] <= merged_line;
            mem_op_q                 <= MEM_WRITE;
            mem_size_q               <= MEM_SIZE_LINE;
            mem_addr_q               <= line_addr;
            mem_wdata_q              <= merged_line;
        end
        // Write miss, no allocate, word in the low bits
        if (start_word_wr) begin
            mem_op_q    <= MEM_WRITE;
            mem_size_q  <= MEM_SIZE_WORD;
            mem_addr_q  <= req_q.addr;
            mem_wdata_q <= {{(`CACHE_LINE_W-`CACHE_WORD_W){1'b0}}, req_q.wdata};
        end
    end

endmodule

`default_nettype wire

//--- hw/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_consts.svh"

module mem_arbiter
    import mem_bus_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset_n,
    input  wire mem_req_t  i_req_0,
    input  wire mem_req_t  i_req_1,
    output mem_rsp_t       o_rsp_0,
    output mem_rsp_t       o_rsp_1,
    output snoop_t         o_snoop_0,
    output snoop_t         o_snoop_1,
    output mem_req_t       o_mem_req,
    input  wire mem_rsp_t  i_mem_rsp
);

    // While busy, last_q is also the granted port
    logic     busy_q;
    logic     last_q;
    logic     snoop_valid_q;
    logic     any_req;
    logic     pick;
    mem_op_e  pick_op;
    mem_req_t sel_req;

    assign any_req = i_req_0.valid || i_req_1.valid;

    // Round robin on contention, otherwise whoever asks
    always_comb begin
        if (i_req_0.valid && i_req_1.valid) begin
            pick = ~last_q;
        end else begin
            pick = i_req_1.valid;
        end
    end

    assign pick_op = pick ? i_req_1.op : i_req_0.op;
    assign sel_req = last_q ? i_req_1 : i_req_0;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            busy_q        <= 1'b0;
            last_q        <= 1'b1;
            snoop_valid_q <= 1'b0;
        end else begin
            snoop_valid_q <= 1'b0;
            if (!busy_q && any_req) begin
                busy_q        <= 1'b1;
                last_q        <= pick;
                snoop_valid_q <= (pick_op == MEM_WRITE);
            end else if (busy_q && i_mem_rsp.ready) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Granted request goes straight through, the cache holds it stable
    always_comb begin
        o_mem_req       = sel_req;
        o_mem_req.valid = busy_q;
    end

    // Ready pulse only to the granted cache
    always_comb begin
        o_rsp_0       = i_mem_rsp;
        o_rsp_1       = i_mem_rsp;
        o_rsp_0.ready = i_mem_rsp.ready && busy_q && !last_q;
        o_rsp_1.ready = i_mem_rsp.ready && busy_q && last_q;
    end

    // Snoop the cache that did not issue the write
    assign o_snoop_0 = '{valid: snoop_valid_q && last_q, addr: sel_req.addr};
    assign o_snoop_1 = '{valid: snoop_valid_q && !last_q, addr: sel_req.addr};

endmodule

`default_nettype wire

//--- hw/cache_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_consts.svh"

module cache_top
    import mem_bus_pkg::*;
    import cache_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset_n,
    input  wire cpu_req_t  i_cpu_req_0,
    input  wire cpu_req_t  i_cpu_req_1,
    output logic           o_cpu_ready_0,
    output logic           o_cpu_ready_1,
    output cpu_rsp_t       o_cpu_rsp_0,
    output cpu_rsp_t       o_cpu_rsp_1,
    output mem_req_t       o_mem_req,
    input  wire mem_rsp_t  i_mem_rsp
);

    // Cache to arbiter traffic
    mem_req_t mem_req_0;
    mem_req_t mem_req_1;
    mem_rsp_t mem_rsp_0;
    mem_rsp_t mem_rsp_1;
    snoop_t   snoop_0;
    snoop_t   snoop_1;

    // Load/store port 0
    cache_ctrl u_cache_0 (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_cpu_req   (i_cpu_req_0),
        .o_cpu_ready (o_cpu_ready_0),
        .o_cpu_rsp   (o_cpu_rsp_0),
        .o_mem_req   (mem_req_0),
        .i_mem_rsp   (mem_rsp_0),
        .i_snoop     (snoop_0)
    );

    // Load/store port 1
    cache_ctrl u_cache_1 (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_cpu_req   (i_cpu_req_1),
        .o_cpu_ready (o_cpu_ready_1),
        .o_cpu_rsp   (o_cpu_rsp_1),
        .o_mem_req   (mem_req_1),
        .i_mem_rsp   (mem_rsp_1),
        .i_snoop     (snoop_1)
    );

    mem_arbiter u_mem_arbiter (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_req_0   (mem_req_0),
        .i_req_1   (mem_req_1),
        .o_rsp_0   (mem_rsp_0),
        .o_rsp_1   (mem_rsp_1),
        .o_snoop_0 (snoop_0),
        .o_snoop_1 (snoop_1),
        .o_mem_req (o_mem_req),
        .i_mem_rsp (i_mem_rsp)
    );

endmodule

`default_nettype wire

//--- test/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_consts.svh"

module tb_mem_model
    import mem_bus_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset_n,
    input  wire mem_req_t  i_req,
    output mem_rsp_t       o_rsp
);

    // Word-addressed storage, preset by the testbench top
    logic [`CACHE_WORD_W-1:0] mem [0:(1 << `CACHE_ADDR_W)-1];

    int       read_count;
    int       write_count;
    int       wait_cnt;
    mem_rsp_t rsp_q = '0;

    assign o_rsp = rsp_q;

    always @(posedge clk) begin
        if (!reset_n) begin
            rsp_q       <= '0;
            wait_cnt    <= 0;
            read_count  <= 0;
            write_count <= 0;
        end else begin
            rsp_q.ready <= 1'b0;
            // Request stays up through the pulse, so skip that cycle
            if (i_req.valid && !rsp_q.ready) begin
                if (wait_cnt == `MEM_LATENCY - 1) begin
                    wait_cnt    <= 0;
                    rsp_q.ready <= 1'b1;
                    if (i_req.op == MEM_READ) begin
                        for (int k = 0; k < `CACHE_LINE_WORDS; k++) begin
                            rsp_q.rdata[k*`CACHE_WORD_W +: `CACHE_WORD_W] <=
                                mem[i_req.addr + 16'(k)];
                        end
                        read_count <= read_count + 1;
                    end else begin
                        if (i_req.size == MEM_SIZE_WORD) begin
                            mem[i_req.addr] <= i_req.wdata[`CACHE_WORD_W-1:0];
                        end else begin
                            for (int k = 0; k < `CACHE_LINE_WORDS; k++) begin
                                mem[i_req.addr + 16'(k)] <=
                                    i_req.wdata[k*`CACHE_WORD_W +: `CACHE_WORD_W];
                            end
                        end
                        write_count <= write_count + 1;
                    end
                end else begin
                    wait_cnt <= wait_cnt + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- test/tb_cache_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_consts.svh"

module tb_cache_top
    import mem_bus_pkg::*;
    import cache_pkg::*;
();

    localparam int WAIT_LIMIT = 40;

    typedef struct packed {
        logic                     port;
        cpu_op_e                  op;
        logic [`CACHE_ADDR_W-1:0] addr;
        logic [`CACHE_WORD_W-1:0] wdata;
        logic [7:0]               rd_delta;
    } test_t;

    logic     clk = 1'b0;
    logic     reset_n;
    cpu_req_t req_0;
    cpu_req_t req_1;
    logic     ready_0;
    logic     ready_1;
    cpu_rsp_t rsp_0;
    cpu_rsp_t rsp_1;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    logic [`CACHE_WORD_W-1:0] ref_mem [0:(1 << `CACHE_ADDR_W)-1];
    test_t                    tests [$];
    logic [`CACHE_ADDR_W-1:0] written [$];
    int                       cycles = 0;
    int                       cycle_limit = 0;
    int                       pass_cnt = 0;
    int                       fail_cnt = 0;
    test_t                    t;
    int                       waited;
    int                       rd_start;
    int                       rd_delta;
    bit                       ok;
    bit                       done;
    logic [`CACHE_WORD_W-1:0] exp_data;
    cpu_rsp_t                 rsp;

    always #50 clk = ~clk;

    cache_top u_cache_top (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_cpu_req_0   (req_0),
        .i_cpu_req_1   (req_1),
        .o_cpu_ready_0 (ready_0),
        .o_cpu_ready_1 (ready_1),
        .o_cpu_rsp_0   (rsp_0),
        .o_cpu_rsp_1   (rsp_1),
        .o_mem_req     (mem_req),
        .i_mem_rsp     (mem_rsp)
    );

    tb_mem_model u_mem_model (
        .clk     (clk),
        .reset_n (reset_n),
        .i_req   (mem_req),
        .o_rsp   (mem_rsp)
    );

    // xorshift32 seeded from the whole word address
    function automatic logic [15:0] mem_fill_value(input logic [15:0] addr);
        logic [31:0] s;
        s = 32'd42927 ^ {addr, ~addr};
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s[15:0];
    endfunction

    function automatic logic port_ready(input logic port);
        return port ? ready_1 : ready_0;
    endfunction

    function automatic cpu_rsp_t port_rsp(input logic port);
        return port ? rsp_1 : rsp_0;
    endfunction

    task automatic drive_port(input logic port, input cpu_req_t r);
        if (port) begin
            req_1 <= r;
        end else begin
            req_0 <= r;
        end
    endtask

    task automatic add_test(input logic port, input cpu_op_e op, input logic [15:0] addr,
                            input logic [15:0] wdata, input logic [7:0] rd_delta);
        tests.push_back('{port: port, op: op, addr: addr, wdata: wdata, rd_delta: rd_delta});
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Run stopped by timeout after %0d cycles", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        reset_n = 1'b0;
        req_0   = '0;
        req_1   = '0;
        for (int a = 0; a < (1 << `CACHE_ADDR_W); a++) begin
            ref_mem[a]           = mem_fill_value(16'(a));
            u_mem_model.mem[a]   = mem_fill_value(16'(a));
        end

        // Miss then hit, write hit, write miss
        add_test(0, CPU_READ,  16'h0001, 16'h0000, 1);
        add_test(0, CPU_READ,  16'h0001, 16'h0000, 0);
        add_test(0, CPU_WRITE, 16'h0002, 16'hA5A5, 0);
        add_test(0, CPU_READ,  16'h0002, 16'h0000, 0);
        add_test(0, CPU_WRITE, 16'h0105, 16'h1234, 0);
        add_test(0, CPU_READ,  16'h0105, 16'h0000, 1);
        // Three tags in set 0, first one gets evicted
        add_test(0, CPU_READ,  16'h0008, 16'h0000, 1);
        add_test(0, CPU_READ,  16'h0010, 16'h0000, 1);
        add_test(0, CPU_READ,  16'h0000, 16'h0000, 1);
        // Port 1 write invalidates port 0 copy
        add_test(0, CPU_READ,  16'h0024, 16'h0000, 1);
        add_test(1, CPU_WRITE, 16'h0025, 16'hBEEF, 0);
        add_test(0, CPU_READ,  16'h0025, 16'h0000, 1);
        // Port 0 line write invalidates port 1 copy
        add_test(1, CPU_READ,  16'h0002, 16'h0000, 1);
        add_test(0, CPU_WRITE, 16'h0003, 16'h5A5A, 0);
        add_test(1, CPU_READ,  16'h0003, 16'h0000, 1);
        cycle_limit = tests.size() * (`MEM_LATENCY + 10) + 100;

        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        if (ready_0 !== 1'b1 || ready_1 !== 1'b1 || mem_req.valid !== 1'b0) begin
            $display("** Error: after reset o_cpu_ready_0=0x%h o_cpu_ready_1=0x%h o_mem_req.valid=0x%h",
                     ready_0, ready_1, mem_req.valid);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
        $display("Test reset: %s", (fail_cnt == 0) ? "ok" : "wrong");

        for (int i = 0; i < tests.size(); i++) begin
            t        = tests[i];
            ok       = 1'b1;
            rd_start = u_mem_model.read_count;
            exp_data = ref_mem[t.addr];
            if (t.op == CPU_WRITE) begin
                ref_mem[t.addr] = t.wdata;
                written.push_back(t.addr);
            end
            @(posedge clk);
            drive_port(t.port, '{valid: 1'b1, op: t.op, addr: t.addr, wdata: t.wdata});
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (!port_ready(t.port) && waited < WAIT_LIMIT);
            if (!port_ready(t.port)) begin
                $display("Test %0d: port %0d never accepted the request", i, t.port);
                ok = 1'b0;
            end
            @(posedge clk);
            drive_port(t.port, '0);
            done   = 1'b0;
            waited = 0;
            while (!done && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
                rsp  = port_rsp(t.port);
                done = (t.op == CPU_READ) ? rsp.valid : port_ready(t.port);
            end
            if (!done) begin
                $display("Test %0d: port %0d never answered the request", i, t.port);
                ok = 1'b0;
            end else if (t.op == CPU_READ && rsp.rdata !== exp_data) begin
                $display("** Error: o_cpu_rsp_%0d.rdata = 0x%h, expected 0x%h",
                         t.port, rsp.rdata, exp_data);
                ok = 1'b0;
            end
            rd_delta = u_mem_model.read_count - rd_start;
            if (rd_delta != t.rd_delta) begin
                $display("** Error: memory read count change = 0x%h, expected 0x%h",
                         rd_delta, t.rd_delta);
                ok = 1'b0;
            end
            if (ok) begin
                pass_cnt++;
            end else begin
                fail_cnt++;
            end
            $display("Test %0d: port %0d %s addr 0x%h %s", i, t.port, t.op.name(), t.addr,
                     ok ? "ok" : "wrong");
        end

        // Let the last posted write drain before checking memory
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (mem_req.valid && waited < WAIT_LIMIT);
        ok = 1'b1;
        foreach (written[k]) begin
            if (u_mem_model.mem[written[k]] !== ref_mem[written[k]]) begin
                $display("** Error: mem[0x%h] = 0x%h, expected 0x%h", written[k],
                         u_mem_model.mem[written[k]], ref_mem[written[k]]);
                ok = 1'b0;
            end
        end
        // One memory write per processor write, word or line
        if (u_mem_model.write_count != written.size()) begin
            $display("** Error: u_mem_model.write_count = 0x%h, expected 0x%h",
                     u_mem_model.write_count, written.size());
            ok = 1'b0;
        end
        if (ok) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        $display("Test memory contents: %s", ok ? "ok" : "wrong");

        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+hw
hw/mem_bus_pkg.sv
hw/cache_pkg.sv
hw/cache_ctrl.sv
hw/mem_arbiter.sv
hw/cache_top.sv
test/tb_mem_model.sv
test/tb_cache_top.sv
